// ==== Makefile ====
# Verilator build and run of the AXI4-Lite identification block testbench

VERILATOR ?= verilator
TOP       ?= tb_axil_id_regs
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TEST RESULT: PASS

SOURCES := $(wildcard src/*.sv sim/*.sv include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, pass only if the pass line is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Output is kept in a shell variable, shown, then searched
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== flist.f ====
+incdir+include
src/axil_id_regs_pkg.sv
src/axil_write_channel.sv
src/axil_reg_bank.sv
src/axil_read_channel.sv
src/axil_id_regs.sv
sim/tb_axil_id_regs.sv

// ==== include/axil_tb_tasks.svh ====
`ifndef axil_tb_tasks_svh
`define axil_tb_tasks_svh

// ------------------------------
// Random source
// ------------------------------

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, shifting right
logic [31:0] lfsr_state = lfsr_seed;

// One LFSR step for every bit handed out
function automatic logic [31:0] random_bits(input int count);
	logic [31:0] value;
	logic lsb;
	value = '0;
	for (int i = 0; i < count; i++)
	begin
		lsb = lfsr_state[0];
		lfsr_state = (lfsr_state >> 1) ^ (lsb ? 32'h8020_0003 : 32'h0);
		value = {value[30:0], lsb};
	end
	return value;
endfunction

// ------------------------------
// Write side
// ------------------------------

// Offer address and data together, wait for the ready pulse
// A ready seen at a falling edge completes on the next rising edge
task automatic write_addr_data(input logic [4:0] index, input logic [31:0] data,
	input logic [3:0] strb);
	s_axi_awaddr = {index, 2'b00};
	s_axi_wdata = data;
	s_axi_wstrb = strb;
	s_axi_awvalid = 1'b1;
	s_axi_wvalid = 1'b1;
	@(negedge S_AXI_ACLK);
	while (!s_axi_awready)
		@(negedge S_AXI_ACLK);
	assert (s_axi_wready)
		else report_failure("write data ready did not rise with the address ready");
	@(negedge S_AXI_ACLK);
	s_axi_awvalid = 1'b0;
	s_axi_wvalid = 1'b0;
	// Identity slots keep no storage
	if (index >= word_ctrl)
		model[index] = merge_bytes(model[index], data, strb);
endtask

// Collect the response, optionally holding BREADY low first
task automatic write_resp(input int b_hold);
	s_axi_bready = (b_hold == 0);
	while (!s_axi_bvalid)
		@(negedge S_AXI_ACLK);
	assert (s_axi_bresp == resp_okay)
		else report_failure($sformatf("error s_axi_bresp expected %01h got %01h",
			resp_okay, s_axi_bresp));
	for (int i = 0; i < b_hold; i++)
	begin
		@(negedge S_AXI_ACLK);
		assert (s_axi_bvalid)
			else report_failure("write response dropped while BREADY was low");
		assert (!s_axi_awready)
			else report_failure("write address accepted while a response was pending");
	end
	s_axi_bready = 1'b1;
	@(negedge S_AXI_ACLK);
	s_axi_bready = 1'b0;
endtask

task automatic bus_write(input logic [4:0] index, input logic [31:0] data,
	input logic [3:0] strb);
	write_addr_data(index, data, strb);
	write_resp(0);
endtask

// ------------------------------
// Read side
// ------------------------------

task automatic read_addr(input logic [4:0] index);
	s_axi_araddr = {index, 2'b00};
	s_axi_arvalid = 1'b1;
	@(negedge S_AXI_ACLK);
	while (!s_axi_arready)
		@(negedge S_AXI_ACLK);
	@(negedge S_AXI_ACLK);
	s_axi_arvalid = 1'b0;
endtask

// Check the returned word, then hold RREADY low for r_hold cycles
task automatic read_data(input logic [4:0] index, input int r_hold);
	logic [31:0] expected;
	expected = expected_word(index);
	s_axi_rready = (r_hold == 0);
	while (!s_axi_rvalid)
		@(negedge S_AXI_ACLK);
	assert (s_axi_rresp == resp_okay)
		else report_failure($sformatf("error s_axi_rresp expected %01h got %01h",
			resp_okay, s_axi_rresp));
	assert (s_axi_rdata == expected)
		else report_failure($sformatf("error s_axi_rdata word %0d expected %08h got %08h",
			index, expected, s_axi_rdata));
	for (int i = 0; i < r_hold; i++)
	begin
		@(negedge S_AXI_ACLK);
		assert (s_axi_rvalid && s_axi_rdata == expected)
			else report_failure($sformatf("error s_axi_rdata held expected %08h got %08h",
				expected, s_axi_rdata));
		assert (!s_axi_arready)
			else report_failure("read address accepted while read data was pending");
	end
	s_axi_rready = 1'b1;
	@(negedge S_AXI_ACLK);
	s_axi_rready = 1'b0;
endtask

task automatic bus_read(input logic [4:0] index);
	read_addr(index);
	read_data(index, 0);
endtask

`endif

// ==== sim/tb_axil_id_regs.sv ====
`timescale 1ns/1ps

module tb_axil_id_regs
	import axil_id_regs_pkg::*;
();

	// ------------------------------
	// Test constants
	// ------------------------------

	localparam int clk_period = 8;
	localparam int reset_cycles = 8;
	localparam logic [31:0] lfsr_seed = 32'h5f16;
	localparam int random_writes = 40;
	// Identity and LED reads, write and read pairs, control writes,
	// ignored writes with reads, back-pressure, final sweep
	localparam int transactions = 10 + 2 * random_writes + 4 + 14 + 4 + 32;
	localparam int timeout_limit = 64 * transactions + reset_cycles;

	logic                  S_AXI_ACLK = 1'b0;
	logic                  S_AXI_ARESETN;
	logic [63:0]           git_hash;
	logic [31:0]           timestamp;
	logic                  led;
	logic                  led3;
	logic [6:0]            s_axi_awaddr;
	logic                  s_axi_awvalid;
	logic                  s_axi_awready;
	logic [data_width-1:0] s_axi_wdata;
	logic [strb_width-1:0] s_axi_wstrb;
	logic                  s_axi_wvalid;
	logic                  s_axi_wready;
	logic [1:0]            s_axi_bresp;
	logic                  s_axi_bvalid;
	logic                  s_axi_bready;
	logic [6:0]            s_axi_araddr;
	logic                  s_axi_arvalid;
	logic                  s_axi_arready;
	logic [data_width-1:0] s_axi_rdata;
	logic [1:0]            s_axi_rresp;
	logic                  s_axi_rvalid;
	logic                  s_axi_rready;
	logic                  led_sel;

	// Reference copy of all 32 words, slots 0 to 6 stay zero
	logic [31:0] model [0:31];
	int cycle_count = 0;

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	// Byte-wise merge, only lanes with a set strobe take new data
	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
		input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] result;
		result = old;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				result[8*b +: 8] = data[8*b +: 8];
		return result;
	endfunction

	// Identity words from the live inputs, writable words from the model
	function automatic logic [31:0] expected_word(input logic [4:0] index);
		case (index)
			5'd0: return git_hash[31:0];
			5'd1: return git_hash[63:32];
			5'd2: return timestamp;
			5'd3: return sig_a_value;
			5'd4: return sig_b_value;
			5'd5: return timestamp;
			5'd6: return {30'b0, led, led3};
			default: return model[index];
		endcase
	endfunction

`include "axil_tb_tasks.svh"

	axil_id_regs #(
		.addr_width(7)
	) axil_id_regs_i (.*);

	always #(clk_period / 2) S_AXI_ACLK = ~S_AXI_ACLK;

	// Run limit, scaled from the transaction count
	always @(posedge S_AXI_ACLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit)
			report_failure($sformatf("timeout, run did not finish in %0d cycles", timeout_limit));
	end

	// ------------------------------
	// Protocol and LED checks
	// ------------------------------

	a_led_sel: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		led_sel == model[word_ctrl][0])
		else report_failure($sformatf("error led_sel expected %01h got %01h",
			$sampled(model[word_ctrl][0]), $sampled(led_sel)));

	a_b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
		else report_failure("write response changed while BREADY was low");

	// no new write address while a response waits
	a_aw_blocked: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_bvalid |-> !s_axi_awready)
		else report_failure("AWREADY rose while BVALID was high");

	a_r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
		else report_failure("read data changed while RREADY was low");

	a_ar_blocked: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid |-> !s_axi_arready)
		else report_failure("ARREADY rose while RVALID was high");

	// ------------------------------
	// Stimulus
	// ------------------------------

	initial
	begin
		logic [4:0] index;
		logic [31:0] data;
		S_AXI_ARESETN = 1'b0;
		git_hash = {random_bits(32), random_bits(32)};
		timestamp = random_bits(32);
		{led, led3} = 2'(random_bits(2));
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		for (int i = 0; i < 32; i++)
			model[i] = '0;
		repeat (reset_cycles) @(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		assert (!(s_axi_awready || s_axi_wready || s_axi_bvalid || s_axi_arready
			|| s_axi_rvalid || led_sel))
			else report_failure("a ready, valid or led_sel output was high after reset");

		// Identity words, then LED status at new levels
		for (int i = 0; i < 7; i++)
			bus_read(5'(i));
		repeat (3)
		begin
			{led, led3} = 2'(random_bits(2));
			bus_read(word_status);
		end

		// Random strobed writes, each read back
		repeat (random_writes)
		begin
			index = 5'(7 + random_bits(5) % 25);
			bus_write(index, random_bits(32), 4'(random_bits(4)));
			bus_read(index);
		end
		repeat (4)
			bus_write(word_ctrl, random_bits(32), 4'hf);

		// Read-only slots take the write and keep their value
		for (int i = 0; i < 7; i++)
			bus_write(5'(i), random_bits(32), 4'hf);
		for (int i = 0; i < 7; i++)
			bus_read(5'(i));

		// Second write already offered while BREADY is low
		write_addr_data(5'd9, random_bits(32), 4'hf);
		data = random_bits(32);
		s_axi_awaddr = {5'd10, 2'b00};
		s_axi_wdata = data;
		s_axi_wstrb = 4'h3;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid = 1'b1;
		write_resp(6);
		write_addr_data(5'd10, data, 4'h3);
		write_resp(0);

		// Second read already offered while RREADY is low
		read_addr(5'd9);
		s_axi_araddr = {word_sig_a, 2'b00};
		s_axi_arvalid = 1'b1;
		read_data(5'd9, 6);
		bus_read(word_sig_a);

		// Whole window against the model
		for (int i = 0; i < 32; i++)
			bus_read(5'(i));
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== src/axil_id_regs.sv ====
`timescale 1ns/1ps

module axil_id_regs
	import axil_id_regs_pkg::*;
#(
	parameter int addr_width = 7
)
(
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	// Identity and status sources
	input  logic [63:0]           git_hash,
	input  logic [31:0]           timestamp,
	input  logic                  led,
	input  logic                  led3,
	// Write address channel
	input  logic [addr_width-1:0] s_axi_awaddr,
	input  logic                  s_axi_awvalid,
	output logic                  s_axi_awready,
	// Write data channel
	input  logic [data_width-1:0] s_axi_wdata,
	input  logic [strb_width-1:0] s_axi_wstrb,
	input  logic                  s_axi_wvalid,
	output logic                  s_axi_wready,
	// Write response channel
	output logic [1:0]            s_axi_bresp,
	output logic                  s_axi_bvalid,
	input  logic                  s_axi_bready,
	// Read address channel
	input  logic [addr_width-1:0] s_axi_araddr,
	input  logic                  s_axi_arvalid,
	output logic                  s_axi_arready,
	// Read data channel
	output logic [data_width-1:0] s_axi_rdata,
	output logic [1:0]            s_axi_rresp,
	output logic                  s_axi_rvalid,
	input  logic                  s_axi_rready,
	// Control output
	output logic                  led_sel
);

	// ------------------------------
	// Internal wires
	// ------------------------------

	// Bank write port from the write channel
	logic                   wr_en;
	logic [index_width-1:0] wr_index;
	logic [data_width-1:0]  wr_data;
	logic [strb_width-1:0]  wr_strb;

	// Bank read port for the read channel
	logic [index_width-1:0] rd_index;
	logic [data_width-1:0]  rd_word;

	// Decode, address and data into a bank write
	axil_write_channel #(
		.addr_width(addr_width)
	) write_channel_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.s_axi_awaddr (s_axi_awaddr),
		.s_axi_awvalid(s_axi_awvalid),
		.s_axi_awready(s_axi_awready),
		.s_axi_wdata  (s_axi_wdata),
		.s_axi_wstrb  (s_axi_wstrb),
		.s_axi_wvalid (s_axi_wvalid),
		.s_axi_wready (s_axi_wready),
		.s_axi_bresp  (s_axi_bresp),
		.s_axi_bvalid (s_axi_bvalid),
		.s_axi_bready (s_axi_bready),
		.wr_en        (wr_en),
		.wr_index     (wr_index),
		.wr_data      (wr_data),
		.wr_strb      (wr_strb)
	);

	// Execute, the writable words
	axil_reg_bank reg_bank_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.wr_en        (wr_en),
		.wr_index     (wr_index),
		.wr_data      (wr_data),
		.wr_strb      (wr_strb),
		.rd_index     (rd_index),
		.rd_word      (rd_word),
		.led_sel      (led_sel)
	);

	// Result, word select and read data
	axil_read_channel #(
		.addr_width(addr_width)
	) read_channel_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.s_axi_araddr (s_axi_araddr),
		.s_axi_arvalid(s_axi_arvalid),
		.s_axi_arready(s_axi_arready),
		.s_axi_rdata  (s_axi_rdata),
		.s_axi_rresp  (s_axi_rresp),
		.s_axi_rvalid (s_axi_rvalid),
		.s_axi_rready (s_axi_rready),
		.git_hash     (git_hash),
		.timestamp    (timestamp),
		.led          (led),
		.led3         (led3),
		.rd_index     (rd_index),
		.rd_word      (rd_word)
	);

endmodule

// ==== src/axil_id_regs_pkg.sv ====
package axil_id_regs_pkg;

	// ------------------------------
	// Bus geometry
	// ------------------------------

	// AXI data width and register word width
	localparam int data_width = 32;

	// One strobe per byte lane
	localparam int strb_width = data_width / 8;

	// Byte offset bits below the word index
	localparam int addr_lsb = 2;

	// Word index width, 32 words in the window
	localparam int index_width = 5;

	// ------------------------------
	// Word map
	// ------------------------------

	// Read-only identity words
	localparam logic [index_width-1:0] word_hash_lo  = 5'd0;
	localparam logic [index_width-1:0] word_hash_hi  = 5'd1;
	localparam logic [index_width-1:0] word_time     = 5'd2;
	localparam logic [index_width-1:0] word_sig_a    = 5'd3;
	localparam logic [index_width-1:0] word_sig_b    = 5'd4;
	localparam logic [index_width-1:0] word_time_alt = 5'd5;
	// LED status, two bits at the bottom
	localparam logic [index_width-1:0] word_status   = 5'd6;

	// First writable word, bit 0 drives led_sel
	localparam logic [index_width-1:0] word_ctrl     = 5'd7;
	// One past the last writable word
	localparam int word_count = 32;

	// Fixed signature words, readable by software to find the block
	localparam logic [data_width-1:0] sig_a_value = 32'hbaaf_deec;
	localparam logic [data_width-1:0] sig_b_value = 32'hdead_0666;

	// AXI OKAY response
	localparam logic [1:0] resp_okay = 2'b00;

endpackage

// ==== src/axil_read_channel.sv ====
`timescale 1ns/1ps

module axil_read_channel
	import axil_id_regs_pkg::*;
#(
	parameter int addr_width = 7
)
(
	input  logic                   S_AXI_ACLK,
	input  logic                   S_AXI_ARESETN,
	// Read address channel
	input  logic [addr_width-1:0]  s_axi_araddr,
	input  logic                   s_axi_arvalid,
	output logic                   s_axi_arready,
	// Read data channel
	output logic [data_width-1:0]  s_axi_rdata,
	output logic [1:0]             s_axi_rresp,
	output logic                   s_axi_rvalid,
	input  logic                   s_axi_rready,
	// Identity and status sources, sampled directly
	input  logic [63:0]            git_hash,
	input  logic [31:0]            timestamp,
	input  logic                   led,
	input  logic                   led3,
	// Bank read port
	output logic [index_width-1:0] rd_index,
	input  logic [data_width-1:0]  rd_word
);

	// Address handshake on this edge
	logic rd_fire;

	// Word chosen by the latched index
	logic [data_width-1:0] rd_sel;

	assign rd_fire = s_axi_arready && s_axi_arvalid;

	// ------------------------------
	// Address acceptance
	// ------------------------------

	// New address only with no read data pending
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			s_axi_arready <= 1'b0;
		else
			s_axi_arready <= !s_axi_arready && s_axi_arvalid && !s_axi_rvalid;
	end

	// Index latched with the ready pulse, valid at the handshake edge
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!s_axi_arready && s_axi_arvalid && !s_axi_rvalid)
			rd_index <= s_axi_araddr[addr_lsb +: index_width];
	end

	// ------------------------------
	// Word select
	// ------------------------------

	always_comb
	begin
		case (rd_index)
			word_hash_lo:  rd_sel = git_hash[31:0];
			word_hash_hi:  rd_sel = git_hash[63:32];
			word_time:     rd_sel = timestamp;
			word_sig_a:    rd_sel = sig_a_value;
			word_sig_b:    rd_sel = sig_b_value;
			// Second copy of the build time
			word_time_alt: rd_sel = timestamp;
			word_status:   rd_sel = {{(data_width-2){1'b0}}, led, led3};
			default:       rd_sel = rd_word;
		endcase
	end

	// ------------------------------
	// Read data register
	// ------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			s_axi_rvalid <= 1'b0;
		else if (rd_fire)
			s_axi_rvalid <= 1'b1;
		else if (s_axi_rready)
			s_axi_rvalid <= 1'b0;
	end

	// Captured once per read, held through back-pressure
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (rd_fire)
			s_axi_rdata <= rd_sel;
	end

	// Every read completes OKAY
	assign s_axi_rresp = resp_okay;

	// ------------------------------
	// Assertions
	// ------------------------------

	// No second address while data waits
	a_no_ar_pending: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(s_axi_arready && s_axi_rvalid));

	// Data and valid hold under back-pressure
	a_rdata_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

// ==== src/axil_reg_bank.sv ====
`timescale 1ns/1ps

module axil_reg_bank
	import axil_id_regs_pkg::*;
(
	input  logic                   S_AXI_ACLK,
	input  logic                   S_AXI_ARESETN,
	// Write port, from the write channel
	input  logic                   wr_en,
	input  logic [index_width-1:0] wr_index,
	input  logic [data_width-1:0]  wr_data,
	input  logic [strb_width-1:0]  wr_strb,
	// Read port, for the read channel
	input  logic [index_width-1:0] rd_index,
	output logic [data_width-1:0]  rd_word,
	// Bit 0 of the control word
	output logic                   led_sel
);

	// Writable words only, identity slots have no storage
	logic [data_width-1:0] bank [word_ctrl:word_count-1];

	// ------------------------------
	// Byte-strobe update
	// ------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			// All writable words start at zero, led_sel low
			for (int i = word_ctrl; i < word_count; i++)
				bank[i] <= '0;
		end
		else if (wr_en && wr_index >= word_ctrl)
		begin
			// Merge only the lanes whose strobe is set
			for (int b = 0; b < strb_width; b++)
			begin
				if (wr_strb[b])
					bank[wr_index][b*8 +: 8] <= wr_data[b*8 +: 8];
			end
		end
		// Writes below word_ctrl fall through and change nothing
	end

	// ------------------------------
	// Read port and control
	// ------------------------------

	// Zero below word_ctrl, read channel supplies those words itself
	assign rd_word = (rd_index >= word_ctrl) ? bank[rd_index] : '0;

	// LED select from the control word
	assign led_sel = bank[word_ctrl][0];

	// ------------------------------
	// Assertions
	// ------------------------------

	// Write channel allows one outstanding write, never back-to-back enables
	a_wr_en_single: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		wr_en |=> !wr_en);

endmodule

// ==== src/axil_write_channel.sv ====
`timescale 1ns/1ps

module axil_write_channel
	import axil_id_regs_pkg::*;
#(
	parameter int addr_width = 7
)
(
	input  logic                   S_AXI_ACLK,
	input  logic                   S_AXI_ARESETN,
	// Write address channel
	input  logic [addr_width-1:0]  s_axi_awaddr,
	input  logic                   s_axi_awvalid,
	output logic                   s_axi_awready,
	// Write data channel
	input  logic [data_width-1:0]  s_axi_wdata,
	input  logic [strb_width-1:0]  s_axi_wstrb,
	input  logic                   s_axi_wvalid,
	output logic                   s_axi_wready,
	// Write response channel
	output logic [1:0]             s_axi_bresp,
	output logic                   s_axi_bvalid,
	input  logic                   s_axi_bready,
	// Bank write port
	output logic                   wr_en,
	output logic [index_width-1:0] wr_index,
	output logic [data_width-1:0]  wr_data,
	output logic [strb_width-1:0]  wr_strb
);

	// High when no write is in flight
	// Cleared at address acceptance, set again at the B handshake
	logic wr_idle;

	// Address and data both offered while idle
	logic accept;

	// Edge that completes the address and data handshakes
	logic wr_fire;

	assign accept = s_axi_awvalid && s_axi_wvalid && wr_idle;
	assign wr_fire = s_axi_awready && s_axi_awvalid && s_axi_wready && s_axi_wvalid;

	// ------------------------------
	// Ready pulses and write gate
	// ------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			s_axi_awready <= 1'b0;
			s_axi_wready <= 1'b0;
			wr_idle <= 1'b1;
		end
		else
		begin
			// One-cycle pulse, wr_idle drops with it so no repeat
			s_axi_awready <= accept;
			s_axi_wready <= accept;
			if (accept)
				wr_idle <= 1'b0;
			else if (s_axi_bvalid && s_axi_bready)
				wr_idle <= 1'b1;
		end
	end

	// ------------------------------
	// Index decode
	// ------------------------------

	// Word index taken from bits addr_lsb upward
	// Upper address bits beyond the window are ignored
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (accept)
			wr_index <= s_axi_awaddr[addr_lsb +: index_width];
	end

	// Bank write, one cycle, data and strobes straight from the W channel
	assign wr_en = wr_fire;
	assign wr_data = s_axi_wdata;
	assign wr_strb = s_axi_wstrb;

	// ------------------------------
	// Write response
	// ------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			s_axi_bvalid <= 1'b0;
		else if (wr_fire)
			s_axi_bvalid <= 1'b1;
		else if (s_axi_bready)
			s_axi_bvalid <= 1'b0;
	end

	// Every write completes OKAY, read-only slots included
	assign s_axi_bresp = resp_okay;

	// ------------------------------
	// Assertions
	// ------------------------------

	// Ready is a single-cycle pulse for each accepted write
	a_ready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_awready |=> !s_axi_awready && !s_axi_wready);

	// No new write taken while the response waits
	a_no_aw_pending: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_bvalid |-> !s_axi_awready && !s_axi_wready);

endmodule
